// File: vlog.f
+incdir+common
common/cache_pkg.sv
cache/cache_ctrl.sv
cache/cache_dpath.sv
hdl/blocking_cache.sv
sim/cache_asserts.sv
sim/cache_tb.sv

// File: sim/cache_tb.sv
// Random testbench for the blocking cache against a shadow model of tags, LRU and dirty bits
// Addresses come from a 24-word pool over sets 0..3; an init also preloads testbench memory
`include "cache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  localparam int NUM_REQ = 400;
  localparam int POOL    = 24;   // 6 tags x 4 sets
  localparam int TIMEOUT = 200;  // Cycles per wait
  localparam logic [`CACHE_TAG_W-1:0] TAG_BASE = 'h123;

  logic                     clk;
  logic                     reset;
  logic                     req_valid;
  logic                     req_ready;
  cache_pkg::req_type_e     req_type;
  logic [`CACHE_ADDR_W-1:0] req_addr;
  logic [`CACHE_DATA_W-1:0] req_data;
  logic                     resp_valid;
  logic                     resp_ready;
  logic [`CACHE_DATA_W-1:0] resp_data;
  logic                     mem_req_valid;
  logic                     mem_req_ready;
  cache_pkg::req_type_e     mem_req_type;
  logic [`CACHE_ADDR_W-1:0] mem_req_addr;
  logic [`CACHE_DATA_W-1:0] mem_req_data;
  logic                     mem_resp_valid;
  logic                     mem_resp_ready;
  logic [`CACHE_DATA_W-1:0] mem_resp_data;

  // Backing store and architectural value per pool word
  logic [`CACHE_DATA_W-1:0] mem        [POOL];
  logic [`CACHE_DATA_W-1:0] expect_val [POOL];
  // Shadow of the tag state
  logic [`CACHE_TAG_W-1:0]  sh_tag   [2][`CACHE_NUM_SETS];
  logic                     sh_valid [2][`CACHE_NUM_SETS];
  logic                     sh_dirty [2][`CACHE_NUM_SETS];
  logic                     sh_lru   [`CACHE_NUM_SETS];  // Victim way
  // Memory requests still expected, in order
  cache_pkg::req_type_e     exp_type [$];
  logic [`CACHE_ADDR_W-1:0] exp_addr [$];
  logic [`CACHE_DATA_W-1:0] exp_data [$];

  int          errors;
  int          n_req;
  int          n_resp;
  logic [31:0] stim_seed;
  logic [31:0] mem_seed;
  int          lat_left;
  logic        mem_busy;

  blocking_cache dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int stim_rand(input int range);
    stim_seed = lcg_step(stim_seed);
    return stim_seed[31:16] % range;  // Upper bits, better period
  endfunction

  function automatic logic [`CACHE_ADDR_W-1:0] pool_addr(input int k);
    logic [`CACHE_TAG_W-1:0]   t;
    logic [`CACHE_INDEX_W-1:0] s;
    t = TAG_BASE + k / 4;
    s = k % 4;
    return {t, s, 2'b00};
  endfunction

  // -1 when outside the pool or not word aligned
  function automatic int pool_index(input logic [`CACHE_ADDR_W-1:0] a);
    int t;
    t = int'(a[`CACHE_ADDR_W-1:`CACHE_INDEX_W+2] - TAG_BASE);
    if (a[1:0] != 2'b00 || a[`CACHE_INDEX_W+1:2] > 3 || t >= POOL / 4) return -1;
    return t * 4 + a[`CACHE_INDEX_W+1:2];
  endfunction

  function automatic logic [31:0] fill_value(input logic [31:0] a);
    return (a * 32'h9E3779B1) ^ {a[15:0], a[31:16]};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  // --------------------
  // Memory responder
  // --------------------
  task automatic serve_mem_request();
    int k;
    cache_pkg::req_type_e t;
    logic [31:0] a;
    logic [31:0] d;
    k = pool_index(mem_req_addr);
    mem_seed = lcg_step(mem_seed);
    lat_left = 1 + mem_seed[31:16] % 6;  // 1 to 6 cycles
    mem_resp_data <= '0;
    if (exp_type.size() == 0) begin
      errors++;
      $display("Memory request at %0d ns when none was expected", $time);
    end else begin
      t = exp_type.pop_front();
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      check("mem_req_type", mem_req_type, t);
      check("mem_req_addr", mem_req_addr, a);
      if (t == cache_pkg::WRITE) check("mem_req_data", mem_req_data, d);
    end
    if (k < 0) begin
      errors++;
      $display("Memory request at %0d ns outside the address pool", $time);
    end else if (mem_req_type == cache_pkg::WRITE) mem[k] = mem_req_data;
    else mem_resp_data <= mem[k];
  endtask

  always @(posedge clk) begin
    if (reset) begin
      mem_req_ready  <= 1'b0;
      mem_resp_valid <= 1'b0;
      mem_busy = 1'b0;
    end else begin
      check("mem_resp_ready", mem_resp_ready, mem_busy);  // High only while a response is owed
      if (mem_busy) begin
        if (mem_resp_valid && mem_resp_ready) begin
          mem_resp_valid <= 1'b0;
          mem_busy = 1'b0;
        end else if (!mem_resp_valid) begin
          if (lat_left > 1) lat_left--;
          else mem_resp_valid <= 1'b1;
        end
      end else if (mem_req_valid && mem_req_ready) begin
        serve_mem_request();
        mem_req_ready <= 1'b0;  // One outstanding access
        mem_busy = 1'b1;
      end else begin
        mem_seed = lcg_step(mem_seed);
        mem_req_ready <= mem_seed[28] | mem_seed[27];  // Ready about 3 cycles in 4
      end
    end
  end

  // Count every response transfer, duplicates included
  always @(posedge clk) begin
    if (!reset && resp_valid && resp_ready) n_resp++;
  end

  // --------------------
  // Shadow model
  // --------------------
  // Queues memory traffic, updates shadow state; fast is the 3-cycle path
  task automatic predict(inout cache_pkg::req_type_e op, input logic [31:0] addr,
                         output logic fast);
    logic [`CACHE_INDEX_W-1:0] set;
    logic [`CACHE_TAG_W-1:0]   tag;
    logic                      h0;
    logic                      h1;
    logic                      way;
    logic [31:0]               vaddr;
    set = addr[`CACHE_INDEX_W+1:2];
    tag = addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W+2];
    h0  = sh_valid[0][set] && sh_tag[0][set] == tag;
    h1  = sh_valid[1][set] && sh_tag[1][set] == tag;
    way = (h0 || h1) ? h1 : sh_lru[set];
    // Init over a dirty victim would lose its data
    if (op == cache_pkg::INIT && !(h0 || h1) && sh_dirty[way][set]) op = cache_pkg::WRITE;
    fast = h0 || h1 || op == cache_pkg::INIT;
    if (!fast) begin
      if (sh_dirty[way][set]) begin
        vaddr = {sh_tag[way][set], set, 2'b00};
        exp_type.push_back(cache_pkg::WRITE);
        exp_addr.push_back(vaddr);
        exp_data.push_back(expect_val[pool_index(vaddr)]);
      end
      exp_type.push_back(cache_pkg::READ);
      exp_addr.push_back({tag, set, 2'b00});
      exp_data.push_back('0);
    end
    sh_tag[way][set]   = tag;
    sh_valid[way][set] = 1'b1;
    sh_lru[set]        = ~way;  // Away from the way just used
    if (op == cache_pkg::WRITE) sh_dirty[way][set] = 1'b1;
    else if (!(h0 || h1) || op == cache_pkg::INIT) sh_dirty[way][set] = 1'b0;
  endtask

  // --------------------
  // Processor side
  // --------------------
  task automatic run_request(input cache_pkg::req_type_e op, input logic [31:0] addr,
                             input logic [31:0] data, output logic [31:0] got,
                             output int lat, output bit ok);
    int cycles;
    req_valid <= 1'b1;
    req_type  <= op;
    req_addr  <= addr;
    req_data  <= data;
    cycles = 0;
    ok     = 1'b0;
    lat    = 0;
    got    = '0;
    while (!ok && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (resp_valid) begin
        errors++;
        $display("Response at %0d ns with no request outstanding", $time);
      end
      if (req_valid && req_ready) ok = 1'b1;
    end
    req_valid <= 1'b0;
    if (!ok) begin
      errors++;
      $display("Timeout at %0d ns waiting for req_ready", $time);
      return;
    end
    n_req++;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (resp_valid && lat == 0) lat = cycles;  // Edges from transfer to first valid
      if (resp_valid && resp_ready) begin
        ok  = 1'b1;
        got = resp_data;
      end
      resp_ready <= (stim_rand(4) != 0);
    end
    if (!ok) begin
      errors++;
      $display("Timeout at %0d ns waiting for the response", $time);
    end
  endtask

  initial begin
    int                   k;
    int                   sel;
    int                   hi;
    int                   lo;
    int                   lat;
    bit                   ok;
    bit                   stop;
    logic                 fast;
    cache_pkg::req_type_e op;
    logic [31:0]          addr;
    logic [31:0]          data;
    logic [31:0]          want;
    logic [31:0]          got;
    errors = 0;
    n_req  = 0;
    n_resp = 0;
    stop   = 1'b0;
    stim_seed = 32'd35;
    mem_seed  = lcg_step(32'd35);
    reset          = 1'b1;
    req_valid      = 1'b0;
    req_type       = cache_pkg::READ;
    req_addr       = '0;
    req_data       = '0;
    resp_ready     = 1'b0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    for (int i = 0; i < POOL; i++) begin
      mem[i]        = fill_value(pool_addr(i));
      expect_val[i] = mem[i];
    end
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      sh_valid[0][s] = 1'b0;
      sh_valid[1][s] = 1'b0;
      sh_dirty[0][s] = 1'b0;
      sh_dirty[1][s] = 1'b0;
      sh_lru[s]      = 1'b0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Idle after reset
    repeat (4) begin
      @(posedge clk);
      check("req_ready", req_ready, 1'b1);
      check("resp_valid", resp_valid, 1'b0);
      check("mem_req_valid", mem_req_valid, 1'b0);
    end

    for (int n = 0; n < NUM_REQ && !stop; n++) begin
      k    = stim_rand(POOL);
      addr = pool_addr(k) | stim_rand(4);  // Byte offset bits ignored
      hi   = stim_rand(65536);
      lo   = stim_rand(65536);
      data = (hi << 16) | lo;
      sel  = stim_rand(8);
      op   = (sel < 3) ? cache_pkg::READ : (sel < 6) ? cache_pkg::WRITE : cache_pkg::INIT;
      want = expect_val[k];
      predict(op, addr, fast);
      if (op != cache_pkg::READ) expect_val[k] = data;
      if (op == cache_pkg::INIT) mem[k] = data;  // Init stands for preloaded contents
      repeat (stim_rand(3)) @(posedge clk);
      run_request(op, addr, data, got, lat, ok);
      if (!ok) stop = 1'b1;
      else begin
        if (op == cache_pkg::READ) check("resp_data", got, want);
        if (fast) check("resp_valid latency", lat, 3);
        if (exp_type.size() != 0) begin
          errors++;
          $display("Memory access missing for request done at %0d ns", $time);
          exp_type.delete();
          exp_addr.delete();
          exp_data.delete();
        end
      end
    end

    repeat (4) begin
      @(posedge clk);
      check("resp_valid", resp_valid, 1'b0);
      check("mem_req_valid", mem_req_valid, 1'b0);
    end
    check("response count", n_resp, n_req);
    errors += dut_i.asserts_i.fail_count;
    $display("Errors: %0d, requests: %0d, responses: %0d", errors, n_req, n_resp);
    if (errors == 0) $display("Simulation finished: PASS");
    else $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/cache_asserts.sv
// Handshake and reset properties, bound into every blocking_cache instance
// Each failure raises $error and bumps fail_count, which the testbench reads
`include "cache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module cache_asserts (
  input logic                     clk,
  input logic                     reset,
  input logic                     req_valid,
  input logic                     req_ready,
  input logic                     resp_valid,
  input logic                     resp_ready,
  input logic                     mem_req_valid,
  input logic                     mem_req_ready,
  input cache_pkg::req_type_e     mem_req_type,
  input logic [`CACHE_ADDR_W-1:0] mem_req_addr,
  input logic [`CACHE_DATA_W-1:0] mem_req_data
);

  int fail_count = 0;

  // --------------------
  // Valid held until ready
  // --------------------
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
      req_valid && !req_ready |=> req_valid)
    else begin
      fail_count++;
      $error("req_valid dropped before req_ready");
    end

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
      resp_valid && !resp_ready |=> resp_valid)
    else begin
      fail_count++;
      $error("resp_valid dropped before resp_ready");
    end

  // Payload only matters for data on a write-back
  a_mem_req_hold: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr)
        && $stable(mem_req_type)
        && (mem_req_type != cache_pkg::WRITE || $stable(mem_req_data)))
    else begin
      fail_count++;
      $error("memory request changed before mem_req_ready");
    end

  // --------------------
  // Exclusive states and reset
  // --------------------
  a_ready_xor_resp: assert property (@(posedge clk) disable iff (reset)
      !(req_ready && resp_valid))
    else begin
      fail_count++;
      $error("req_ready and resp_valid high together");
    end

  a_reset_mem_idle: assert property (@(posedge clk) reset |=> !mem_req_valid)
    else begin
      fail_count++;
      $error("mem_req_valid high right after reset");
    end

endmodule

bind blocking_cache cache_asserts asserts_i (
  .clk, .reset, .req_valid, .req_ready, .resp_valid, .resp_ready,
  .mem_req_valid, .mem_req_ready, .mem_req_type, .mem_req_addr, .mem_req_data
);

`default_nettype wire

// File: hdl/blocking_cache.sv
// Blocking 2-way write-back cache top, one request at a time
// Processor and memory streams use valid/ready; lines are one word
`include "cache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module blocking_cache (
  input  logic                      clk,
  input  logic                      reset,
  // Processor request
  input  logic                      req_valid,
  output logic                      req_ready,
  input  cache_pkg::req_type_e      req_type,
  input  logic [`CACHE_ADDR_W-1:0]  req_addr,
  input  logic [`CACHE_DATA_W-1:0]  req_data,
  // Processor response
  output logic                      resp_valid,
  input  logic                      resp_ready,
  output logic [`CACHE_DATA_W-1:0]  resp_data,
  // Memory request
  output logic                      mem_req_valid,
  input  logic                      mem_req_ready,
  output cache_pkg::req_type_e      mem_req_type,
  output logic [`CACHE_ADDR_W-1:0]  mem_req_addr,
  output logic [`CACHE_DATA_W-1:0]  mem_req_data,
  // Memory response
  input  logic                      mem_resp_valid,
  output logic                      mem_resp_ready,
  input  logic [`CACHE_DATA_W-1:0]  mem_resp_data
);

  // Ctrl to datapath
  logic req_reg_en;
  logic way_reg_en;
  logic refill_reg_en;
  logic tag_wen;
  logic data_wen;
  logic data_from_mem;
  logic valid_wen;
  logic dirty_set;
  logic dirty_wen;
  logic lru_wen;
  logic read_reg_en;
  logic evict_sel;
  logic mem_req_write;
  // Datapath to ctrl
  logic                 hit;
  logic                 victim_dirty;
  cache_pkg::req_type_e req_type_q;

  cache_ctrl ctrl_i (
    .clk, .reset,
    .req_valid, .req_ready, .resp_valid, .resp_ready,
    .mem_req_valid, .mem_req_ready, .mem_resp_valid, .mem_resp_ready,
    .hit, .victim_dirty, .req_type (req_type_q),
    .req_reg_en, .way_reg_en, .refill_reg_en, .tag_wen, .data_wen,
    .data_from_mem, .valid_wen, .dirty_set, .dirty_wen, .lru_wen,
    .read_reg_en, .evict_sel, .mem_req_write
  );

  cache_dpath dpath_i (
    .clk, .reset,
    .req_type, .req_addr, .req_data, .mem_resp_data,
    .req_reg_en, .way_reg_en, .refill_reg_en, .tag_wen, .data_wen,
    .data_from_mem, .valid_wen, .dirty_set, .dirty_wen, .lru_wen,
    .read_reg_en, .evict_sel, .mem_req_write,
    .req_type_q, .hit, .victim_dirty, .resp_data,
    .mem_req_type, .mem_req_addr, .mem_req_data
  );

endmodule

`default_nettype wire

// File: cache/cache_dpath.sv
// Blocking cache datapath, 2 ways of one-word lines
// Arrays read combinationally from the registered index; byte offset ignored
`include "cache_config.svh"
`timescale 1ns/1ps
`default_nettype none

module cache_dpath (
  input  logic                      clk,
  input  logic                      reset,
  // Request payload
  input  cache_pkg::req_type_e      req_type,
  input  logic [`CACHE_ADDR_W-1:0]  req_addr,
  input  logic [`CACHE_DATA_W-1:0]  req_data,
  input  logic [`CACHE_DATA_W-1:0]  mem_resp_data,
  // Enables from ctrl
  input  logic                      req_reg_en,
  input  logic                      way_reg_en,
  input  logic                      refill_reg_en,
  input  logic                      tag_wen,
  input  logic                      data_wen,
  input  logic                      data_from_mem,
  input  logic                      valid_wen,
  input  logic                      dirty_set,
  input  logic                      dirty_wen,
  input  logic                      lru_wen,
  input  logic                      read_reg_en,
  input  logic                      evict_sel,
  input  logic                      mem_req_write,
  // Status and payloads out
  output cache_pkg::req_type_e      req_type_q,
  output logic                      hit,
  output logic                      victim_dirty,
  output logic [`CACHE_DATA_W-1:0]  resp_data,
  output cache_pkg::req_type_e      mem_req_type,
  output logic [`CACHE_ADDR_W-1:0]  mem_req_addr,
  output logic [`CACHE_DATA_W-1:0]  mem_req_data
);

  logic [`CACHE_ADDR_W-1:0]  addr_q;
  logic [`CACHE_DATA_W-1:0]  data_q;
  logic [`CACHE_DATA_W-1:0]  refill_q;
  logic [`CACHE_DATA_W-1:0]  read_q;    // Response data or victim data
  logic                      way_q;
  logic [`CACHE_INDEX_W-1:0] idx;
  logic [`CACHE_TAG_W-1:0]   tag;
  logic [1:0]                match;
  logic                      lru_way;
  logic [`CACHE_DATA_W-1:0]  wr_data;

  // Storage, way-major
  logic [`CACHE_TAG_W-1:0]   tag_mem  [2][`CACHE_NUM_SETS];
  logic [`CACHE_DATA_W-1:0]  data_mem [2][`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_bits [2];
  logic [`CACHE_NUM_SETS-1:0] dirty_bits [2];
  logic [`CACHE_NUM_SETS-1:0] lru_bits;   // Points at the victim way

  // --------------------
  // Request register
  // --------------------
  always_ff @(posedge clk) begin
    if (req_reg_en) begin
      req_type_q <= req_type;
      addr_q     <= req_addr;
      data_q     <= req_data;
    end
  end

  assign idx = addr_q[`CACHE_INDEX_W+1:2];
  assign tag = addr_q[`CACHE_ADDR_W-1:`CACHE_INDEX_W+2];

  // --------------------
  // Hit and victim
  // --------------------
  assign match[0]     = valid_bits[0][idx] && (tag_mem[0][idx] == tag);
  assign match[1]     = valid_bits[1][idx] && (tag_mem[1][idx] == tag);
  assign hit          = |match;
  assign lru_way      = lru_bits[idx];
  assign victim_dirty = dirty_bits[lru_way][idx];  // Only meaningful on a miss

  // Chosen way, held until next request
  always_ff @(posedge clk) begin
    if (reset)           way_q <= 1'b0;
    else if (way_reg_en) way_q <= hit ? match[1] : lru_way;
  end

  // --------------------
  // Arrays
  // --------------------
  assign wr_data = data_from_mem ? refill_q : data_q;

  always_ff @(posedge clk) begin
    if (tag_wen)  tag_mem[way_q][idx]  <= tag;
    if (data_wen) data_mem[way_q][idx] <= wr_data;
  end

  // Status bits reset to invalid, clean, victim way 0
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits[0] <= '0;
      valid_bits[1] <= '0;
      dirty_bits[0] <= '0;
      dirty_bits[1] <= '0;
      lru_bits      <= '0;
    end else begin
      if (valid_wen) valid_bits[way_q][idx] <= 1'b1;
      if (dirty_wen) dirty_bits[way_q][idx] <= dirty_set;
      if (lru_wen)   lru_bits[idx]          <= ~way_q;  // Away from way just used
    end
  end

  // Refill capture and read-out registers
  always_ff @(posedge clk) begin
    if (refill_reg_en) refill_q <= mem_resp_data;
    if (read_reg_en)   read_q   <= data_mem[way_q][idx];
  end

  // --------------------
  // Outputs
  // --------------------
  assign resp_data    = read_q;
  assign mem_req_data = read_q;   // Victim word, read type ignores it
  assign mem_req_type = mem_req_write ? cache_pkg::WRITE : cache_pkg::READ;
  // Victim line address on eviction, else request line address
  assign mem_req_addr = {(evict_sel ? tag_mem[way_q][idx] : tag), idx, 2'b00};

endmodule

`default_nettype wire

// File: cache/cache_ctrl.sv
// Blocking cache control FSM, one request in flight
// All outputs decode from the state register; refill capture also needs mem_resp_valid
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  // Handshakes
  input  logic                 req_valid,
  output logic                 req_ready,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output logic                 mem_req_valid,
  input  logic                 mem_req_ready,
  input  logic                 mem_resp_valid,
  output logic                 mem_resp_ready,
  // Status from datapath
  input  logic                 hit,
  input  logic                 victim_dirty,
  input  cache_pkg::req_type_e req_type,   // Registered request type
  // Datapath enables
  output logic                 req_reg_en,
  output logic                 way_reg_en,
  output logic                 refill_reg_en,
  output logic                 tag_wen,
  output logic                 data_wen,
  output logic                 data_from_mem,
  output logic                 valid_wen,
  output logic                 dirty_set,
  output logic                 dirty_wen,
  output logic                 lru_wen,
  output logic                 read_reg_en,
  output logic                 evict_sel,
  output logic                 mem_req_write
);

  cache_pkg::cache_state_e state_q;
  cache_pkg::cache_state_e state_d;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) state_q <= cache_pkg::IDLE;
    else       state_q <= state_d;
  end

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_d = state_q;  // Hold by default
    case (state_q)
      cache_pkg::IDLE:           if (req_valid) state_d = cache_pkg::TAG_CHECK;
      cache_pkg::TAG_CHECK: begin
        if (req_type == cache_pkg::INIT)
          state_d = cache_pkg::INIT_ACCESS;    // Init overwrites, hit or not
        else if (hit)
          state_d = (req_type == cache_pkg::READ) ? cache_pkg::READ_ACCESS
                                                  : cache_pkg::WRITE_ACCESS;
        else if (victim_dirty)
          state_d = cache_pkg::EVICT_PREPARE;  // Write back first
        else
          state_d = cache_pkg::REFILL_REQUEST;
      end
      cache_pkg::INIT_ACCESS,
      cache_pkg::READ_ACCESS,
      cache_pkg::WRITE_ACCESS:   state_d = cache_pkg::WAIT;
      cache_pkg::EVICT_PREPARE:  state_d = cache_pkg::EVICT_REQUEST;
      cache_pkg::EVICT_REQUEST:  if (mem_req_ready) state_d = cache_pkg::EVICT_WAIT;
      cache_pkg::EVICT_WAIT:     if (mem_resp_valid) state_d = cache_pkg::REFILL_REQUEST;
      cache_pkg::REFILL_REQUEST: if (mem_req_ready) state_d = cache_pkg::REFILL_WAIT;
      cache_pkg::REFILL_WAIT:    if (mem_resp_valid) state_d = cache_pkg::REFILL_UPDATE;
      cache_pkg::REFILL_UPDATE: begin
        // Replay the original access on the fresh line
        if (req_type == cache_pkg::READ)       state_d = cache_pkg::READ_ACCESS;
        else if (req_type == cache_pkg::WRITE) state_d = cache_pkg::WRITE_ACCESS;
        else                                   state_d = cache_pkg::WAIT;
      end
      cache_pkg::WAIT:           if (resp_ready) state_d = cache_pkg::IDLE;
      default:                   state_d = cache_pkg::IDLE;
    endcase
  end

  // --------------------
  // Output table
  // --------------------
  always_comb begin
    // Everything off unless a state says otherwise
    req_ready      = 1'b0;
    resp_valid     = 1'b0;
    mem_req_valid  = 1'b0;
    mem_resp_ready = 1'b0;
    req_reg_en     = 1'b0;
    way_reg_en     = 1'b0;
    refill_reg_en  = 1'b0;
    tag_wen        = 1'b0;
    data_wen       = 1'b0;
    data_from_mem  = 1'b0;
    valid_wen      = 1'b0;
    dirty_set      = 1'b0;
    dirty_wen      = 1'b0;
    lru_wen        = 1'b0;
    read_reg_en    = 1'b0;
    evict_sel      = 1'b0;
    mem_req_write  = 1'b0;
    case (state_q)
      cache_pkg::IDLE: begin
        req_ready  = 1'b1;
        req_reg_en = 1'b1;  // Last load is the transfer cycle
      end
      cache_pkg::TAG_CHECK:     way_reg_en = 1'b1;  // Hit way or LRU victim
      cache_pkg::INIT_ACCESS: begin
        tag_wen   = 1'b1;
        data_wen  = 1'b1;
        valid_wen = 1'b1;
        dirty_wen = 1'b1;   // Clean line
        lru_wen   = 1'b1;
      end
      cache_pkg::READ_ACCESS: begin
        read_reg_en = 1'b1;
        lru_wen     = 1'b1;
      end
      cache_pkg::WRITE_ACCESS: begin
        tag_wen   = 1'b1;
        data_wen  = 1'b1;
        valid_wen = 1'b1;
        dirty_set = 1'b1;
        dirty_wen = 1'b1;
        lru_wen   = 1'b1;
      end
      cache_pkg::EVICT_PREPARE: begin
        read_reg_en   = 1'b1;  // Capture victim data
        evict_sel     = 1'b1;
        mem_req_write = 1'b1;
      end
      cache_pkg::EVICT_REQUEST: begin
        mem_req_valid = 1'b1;
        evict_sel     = 1'b1;
        mem_req_write = 1'b1;
      end
      cache_pkg::EVICT_WAIT:     mem_resp_ready = 1'b1;  // Write ack, data dropped
      cache_pkg::REFILL_REQUEST: mem_req_valid  = 1'b1;
      cache_pkg::REFILL_WAIT: begin
        mem_resp_ready = 1'b1;
        refill_reg_en  = mem_resp_valid;
      end
      cache_pkg::REFILL_UPDATE: begin
        tag_wen       = 1'b1;
        data_wen      = 1'b1;
        data_from_mem = 1'b1;
        valid_wen     = 1'b1;
        dirty_wen     = 1'b1;  // Fresh line is clean
      end
      cache_pkg::WAIT:           resp_valid = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: common/cache_pkg.sv
// Shared types for the blocking cache
// Request type encoding also used on the memory request (READ/WRITE only)
`default_nettype none

package cache_pkg;

  // Request type, same codes on processor and memory side
  typedef enum logic [1:0] {
    READ  = 2'd0,
    WRITE = 2'd1,
    INIT  = 2'd2   // Write-init, never goes to memory
  } req_type_e;

  // Control FSM states
  typedef enum logic [3:0] {
    IDLE           = 4'd0,
    TAG_CHECK      = 4'd1,
    INIT_ACCESS    = 4'd2,
    READ_ACCESS    = 4'd3,
    WRITE_ACCESS   = 4'd4,
    EVICT_PREPARE  = 4'd5,
    EVICT_REQUEST  = 4'd6,
    EVICT_WAIT     = 4'd7,
    REFILL_REQUEST = 4'd8,
    REFILL_WAIT    = 4'd9,
    REFILL_UPDATE  = 4'd10,
    WAIT           = 4'd11
  } cache_state_e;

endpackage

`default_nettype wire

// File: common/cache_config.svh
// Cache geometry for the 2-way, one-word-line cache
// Byte offset is 2 bits and ignored; TAG_W must equal ADDR_W - INDEX_W - 2
// Include before the including file switches its own net type
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`default_nettype none

// --------------------
// Address and data
// --------------------
`define CACHE_ADDR_W   32  // Byte address
`define CACHE_DATA_W   32  // One word per line

// --------------------
// Set mapping
// --------------------
`define CACHE_NUM_SETS 8   // Sets per way
`define CACHE_INDEX_W  3   // log2 of set count, bits [4:2]
`define CACHE_TAG_W    27  // Bits [31:5]

`default_nettype wire

`endif
